// File: cdc_fifo/cdc_fifo.sv
`timescale 1ns/1ps

module cdc_fifo #(
    parameter int  ADDR_W    = sample_pkg::FIFO_AW_DEF,
    parameter type payload_t = logic [7:0]
) (
    input  logic     wclk,
    input  logic     rclk,
    input  logic     rrst,
    // write side
    input  logic     push_i,
    input  payload_t wdata_i,
    output logic     full_o,
    // read side
    input  logic     pop_i,
    output payload_t rdata_o,
    output logic     empty_o
);

    localparam int DEPTH = 1 << ADDR_W;

    payload_t mem [DEPTH];

    // pointers carry one extra wrap bit
    logic [ADDR_W:0] wbin_q;
    logic [ADDR_W:0] wbin_next;
    logic [ADDR_W:0] wgray_q;
    logic [ADDR_W:0] wgray_next;
    logic [ADDR_W:0] rbin_q;
    logic [ADDR_W:0] rbin_next;
    logic [ADDR_W:0] rgray_q;
    logic [ADDR_W:0] rgray_next;

    // crossing stages
    logic [ADDR_W:0] rq1_wgray;
    logic [ADDR_W:0] rq2_wgray;
    logic [ADDR_W:0] wq1_rgray;
    logic [ADDR_W:0] wq2_rgray;

    logic [ADDR_W:0] full_match;

    function automatic logic [ADDR_W:0] bin2gray(input logic [ADDR_W:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    // write domain
    assign wbin_next  = wbin_q + (push_i ? 1'b1 : 1'b0);
    assign wgray_next = bin2gray(wbin_next);

    always_ff @(posedge wclk) begin
        if (rrst) begin
            wbin_q  <= '0;
            wgray_q <= '0;
        end else begin
            wbin_q  <= wbin_next;
            wgray_q <= wgray_next;
        end
    end

    always_ff @(posedge wclk) begin
        if (push_i) begin
            mem[wbin_q[ADDR_W-1:0]] <= wdata_i;
        end
    end

    // read domain
    assign rbin_next  = rbin_q + (pop_i ? 1'b1 : 1'b0);
    assign rgray_next = bin2gray(rbin_next);

    always_ff @(posedge rclk) begin
        if (rrst) begin
            rbin_q  <= '0;
            rgray_q <= '0;
        end else begin
            rbin_q  <= rbin_next;
            rgray_q <= rgray_next;
        end
    end

    // head entry, shown without a pop
    assign rdata_o = mem[rbin_q[ADDR_W-1:0]];

    // write pointer into rclk
    always_ff @(posedge rclk) begin
        if (rrst) begin
            rq1_wgray <= '0;
            rq2_wgray <= '0;
        end else begin
            rq1_wgray <= wgray_q;
            rq2_wgray <= rq1_wgray;
        end
    end

    // read pointer into wclk
    always_ff @(posedge wclk) begin
        if (rrst) begin
            wq1_rgray <= '0;
            wq2_rgray <= '0;
        end else begin
            wq1_rgray <= rgray_q;
            wq2_rgray <= wq1_rgray;
        end
    end

    assign empty_o = (rq2_wgray == rgray_q);

    // full: top two gray bits inverted, rest equal
    assign full_match = {~wq2_rgray[ADDR_W:ADDR_W-1], wq2_rgray[ADDR_W-2:0]};
    assign full_o     = (wgray_q == full_match);

    no_push_full_a: assert property (
        @(posedge wclk) disable iff (rrst)
        push_i |-> !full_o
    );

    no_pop_empty_a: assert property (
        @(posedge rclk) disable iff (rrst)
        pop_i |-> !empty_o
    );

endmodule

// File: common/sample_pkg.sv
package sample_pkg;

    // sample payload width
    localparam int SAMPLE_W = 8;

    // per-channel sequence count, wraps
    localparam int SEQ_W = 3;

    // channel number width
    localparam int CHAN_W = 1;

    // defaults handed to the top level
    localparam int N_CHAN_DEF  = 2;
    localparam int FIFO_AW_DEF = 2;

    // one word as it travels through the FIFO
    typedef struct packed {
        logic [CHAN_W-1:0]   chan;
        logic [SEQ_W-1:0]    seq;
        logic [SAMPLE_W-1:0] sample;
    } tagged_sample_t;

endpackage

// File: compile.f
common/sample_pkg.sv
hdl/sample_channel.sv
hdl/rr_arbiter.sv
cdc_fifo/cdc_fifo.sv
hdl/sample_drain.sv
hdl/sample_top.sv
tb/sample_tb.sv

// File: hdl/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int N_CHAN = sample_pkg::N_CHAN_DEF
) (
    input  logic                                    wclk,
    input  logic                                    rrst,
    input  logic [N_CHAN-1:0]                       req_i,
    input  sample_pkg::tagged_sample_t [N_CHAN-1:0] word_i,
    input  logic                                    full_i,
    output logic [N_CHAN-1:0]                       grant_o,
    output logic                                    push_o,
    output sample_pkg::tagged_sample_t              wdata_o
);

    localparam int IDX_W = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;

    logic [IDX_W-1:0] ptr_q;
    logic [IDX_W-1:0] sel;
    logic             found;

    // search starts at the channel after the last winner
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = '0;
        for (int i = 0; i < N_CHAN; i++) begin
            idx = (int'(ptr_q) + i) % N_CHAN;
            if (!found && req_i[idx]) begin
                found = 1'b1;
                sel   = IDX_W'(idx);
            end
        end
    end

    // nothing is granted while the FIFO is full
    always_comb begin
        grant_o = '0;
        if (found && !full_i) begin
            grant_o[sel] = 1'b1;
        end
    end

    assign push_o  = found && !full_i;
    assign wdata_o = word_i[sel];

    always_ff @(posedge wclk) begin
        if (rrst) begin
            ptr_q <= '0;
        end else if (push_o) begin
            if (sel == IDX_W'(N_CHAN - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= sel + 1'b1;
            end
        end
    end

    grant_onehot_a: assert property (
        @(posedge wclk) disable iff (rrst)
        $onehot0(grant_o)
    );

    // push and grant must agree with the channel side
    push_full_a: assert property (
        @(posedge wclk) disable iff (rrst)
        push_o |-> !full_i && (grant_o != '0)
    );

endmodule

// File: hdl/sample_channel.sv
`timescale 1ns/1ps

module sample_channel (
    input  logic                            wclk,
    input  logic                            rrst,
    input  logic                            sample_stb_i,
    input  logic [sample_pkg::SAMPLE_W-1:0] sample_i,
    input  logic                            grant_i,
    input  logic [sample_pkg::CHAN_W-1:0]   chan_id_i,
    output logic                            req_o,
    output sample_pkg::tagged_sample_t      word_o,
    output logic                            overrun_o
);
    import sample_pkg::*;

    logic [SEQ_W-1:0] seq_q;
    logic             capture;
    logic             drop;

    // a strobe is taken only while nothing is pending
    assign capture = sample_stb_i && !req_o;
    assign drop    = sample_stb_i && req_o;

    always_ff @(posedge wclk) begin
        if (rrst) begin
            req_o     <= 1'b0;
            seq_q     <= '0;
            overrun_o <= 1'b0;
        end else begin
            if (capture) begin
                req_o <= 1'b1;
            end else if (grant_i) begin
                req_o <= 1'b0;
            end
            // count advances once the word has gone into the FIFO
            if (grant_i) begin
                seq_q <= seq_q + 1'b1;
            end
            // sticky until reset
            if (drop) begin
                overrun_o <= 1'b1;
            end
        end
    end

    // held word, stable while req is up
    always_ff @(posedge wclk) begin
        if (capture) begin
            word_o.chan   <= chan_id_i;
            word_o.seq    <= seq_q;
            word_o.sample <= sample_i;
        end
    end

    // pending sample leaves only through a grant
    req_held_a: assert property (
        @(posedge wclk) disable iff (rrst)
        req_o && !grant_i |=> req_o
    );

    // arbiter must not grant an idle channel
    grant_req_a: assert property (
        @(posedge wclk) disable iff (rrst)
        grant_i |-> req_o
    );

endmodule

// File: hdl/sample_drain.sv
`timescale 1ns/1ps

module sample_drain #(
    parameter int N_CHAN = sample_pkg::N_CHAN_DEF
) (
    input  logic                       rclk,
    input  logic                       rrst,
    input  sample_pkg::tagged_sample_t rdata_i,
    input  logic                       empty_i,
    input  logic                       hold_i,
    output logic                       pop_o,
    output logic                       out_stb_o,
    output sample_pkg::tagged_sample_t out_word_o,
    output logic                       seq_err_o
);
    import sample_pkg::*;

    // per-channel tracking
    logic [N_CHAN-1:0] seen_q;
    logic [SEQ_W-1:0]  exp_q [N_CHAN];
    logic              gap;

    // drain whenever the consumer lets us
    assign pop_o = !empty_i && !hold_i;

    // first word of a channel only sets the expectation
    assign gap = seen_q[rdata_i.chan] && (rdata_i.seq != exp_q[rdata_i.chan]);

    always_ff @(posedge rclk) begin
        if (rrst) begin
            out_stb_o <= 1'b0;
        end else begin
            out_stb_o <= pop_o;
        end
    end

    always_ff @(posedge rclk) begin
        if (pop_o) begin
            out_word_o <= rdata_i;
        end
    end

    always_ff @(posedge rclk) begin
        if (rrst) begin
            seen_q    <= '0;
            seq_err_o <= 1'b0;
            for (int i = 0; i < N_CHAN; i++) begin
                exp_q[i] <= '0;
            end
        end else if (pop_o) begin
            seen_q[rdata_i.chan] <= 1'b1;
            exp_q[rdata_i.chan]  <= rdata_i.seq + 1'b1;
            if (gap) begin
                seq_err_o <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/sample_top.sv
`timescale 1ns/1ps

module sample_top #(
    parameter int N_CHAN = sample_pkg::N_CHAN_DEF,
    parameter int ADDR_W = sample_pkg::FIFO_AW_DEF
) (
    input  logic                                        wclk,
    input  logic                                        rclk,
    input  logic                                        rrst,
    input  logic [N_CHAN-1:0]                           sample_stb_i,
    input  logic [N_CHAN-1:0][sample_pkg::SAMPLE_W-1:0] sample_i,
    input  logic                                        hold_i,
    output logic                                        out_stb_o,
    output sample_pkg::tagged_sample_t                  out_word_o,
    output logic [N_CHAN-1:0]                           overrun_o,
    output logic                                        seq_err_o
);
    import sample_pkg::*;

    // channels to arbiter
    logic [N_CHAN-1:0]           req;
    logic [N_CHAN-1:0]           grant;
    tagged_sample_t [N_CHAN-1:0] word;

    // arbiter to FIFO
    logic           push;
    logic           full;
    tagged_sample_t wdata;

    // FIFO to drain
    logic           pop;
    logic           empty;
    tagged_sample_t rdata;

    for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
        sample_channel u_chan (
            .wclk         (wclk),
            .rrst         (rrst),
            .sample_stb_i (sample_stb_i[i]),
            .sample_i     (sample_i[i]),
            .grant_i      (grant[i]),
            .chan_id_i    (CHAN_W'(i)),
            .req_o        (req[i]),
            .word_o       (word[i]),
            .overrun_o    (overrun_o[i])
        );
    end

    rr_arbiter #(
        .N_CHAN (N_CHAN)
    ) u_arb (
        .wclk    (wclk),
        .rrst    (rrst),
        .req_i   (req),
        .word_i  (word),
        .full_i  (full),
        .grant_o (grant),
        .push_o  (push),
        .wdata_o (wdata)
    );

    cdc_fifo #(
        .ADDR_W    (ADDR_W),
        .payload_t (tagged_sample_t)
    ) u_fifo (
        .wclk    (wclk),
        .rclk    (rclk),
        .rrst    (rrst),
        .push_i  (push),
        .wdata_i (wdata),
        .full_o  (full),
        .pop_i   (pop),
        .rdata_o (rdata),
        .empty_o (empty)
    );

    sample_drain #(
        .N_CHAN (N_CHAN)
    ) u_drain (
        .rclk       (rclk),
        .rrst       (rrst),
        .rdata_i    (rdata),
        .empty_i    (empty),
        .hold_i     (hold_i),
        .pop_o      (pop),
        .out_stb_o  (out_stb_o),
        .out_word_o (out_word_o),
        .seq_err_o  (seq_err_o)
    );

endmodule

// File: tb/sample_tb.sv
`timescale 1ns/1ps

module sample_tb;
    import sample_pkg::*;

    localparam int N_CHAN      = N_CHAN_DEF;
    localparam int HIST_DEPTH  = 1024;
    localparam int SPARSE_CYC  = 400;
    localparam int PAIR_CYC    = 300;
    localparam int BP_CYC      = 400;
    localparam int STIM_CYC    = 2 + SPARSE_CYC + PAIR_CYC + BP_CYC;
    localparam int TIMEOUT_CYC = 2 * STIM_CYC + 200;
    localparam int QUIET_CYC   = 40;

    logic                            wclk = 1'b0;
    logic                            rclk = 1'b0;
    logic                            rrst;
    logic [N_CHAN-1:0]               sample_stb_i;
    logic [N_CHAN-1:0][SAMPLE_W-1:0] sample_i;
    logic                            hold_i = 1'b0;
    logic                            out_stb_o;
    tagged_sample_t                  out_word_o;
    logic [N_CHAN-1:0]               overrun_o;
    logic                            seq_err_o;

    // per-channel history of strobed samples, consumed by the output monitor
    logic [SAMPLE_W-1:0] hist [N_CHAN][HIST_DEPTH];
    int                  wr_idx [N_CHAN];
    int                  rd_idx [N_CHAN];
    int                  delivered [N_CHAN];
    int                  total_out  = 0;
    bit                  allow_drop = 1'b0;
    logic                hold_req   = 1'b0;
    int                  cycle_cnt  = 0;

    sample_top #(
        .N_CHAN (N_CHAN),
        .ADDR_W (FIFO_AW_DEF)
    ) dut0 (
        .wclk         (wclk),
        .rclk         (rclk),
        .rrst         (rrst),
        .sample_stb_i (sample_stb_i),
        .sample_i     (sample_i),
        .hold_i       (hold_i),
        .out_stb_o    (out_stb_o),
        .out_word_o   (out_word_o),
        .overrun_o    (overrun_o),
        .seq_err_o    (seq_err_o)
    );

    always #50 wclk = ~wclk;
    always #65 rclk = ~rclk;

    // consumer hold lives in the read domain
    always @(posedge rclk) begin
        hold_i <= hold_req;
    end

    always @(posedge wclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout after %0d wclk cycles, outputs never arrived", TIMEOUT_CYC);
            $display("Some tests failed");
            $fatal(1, "run stopped by timeout");
        end
    end

    task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                                 input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // output monitor, registered outputs read before they update
    always @(posedge rclk) begin
        int c;
        if (!rrst) begin
            compare_value(seq_err_o, 1'b0, "seq_err_o stays low");
            if (out_stb_o) begin
                c = int'(out_word_o.chan);
                if (allow_drop) begin
                    // skip strobes that the channel dropped
                    while (rd_idx[c] < wr_idx[c] && hist[c][rd_idx[c]] !== out_word_o.sample) begin
                        rd_idx[c]++;
                    end
                end
                compare_value(rd_idx[c] < wr_idx[c], 1'b1, "output has a strobed sample");
                compare_value(out_word_o.sample, hist[c][rd_idx[c]], "sample value");
                // sequence count advances once per delivered word
                compare_value(out_word_o.seq, delivered[c] % (1 << SEQ_W), "sequence number");
                rd_idx[c]++;
                delivered[c]++;
                total_out++;
            end
        end
    end

    task automatic drive_cycle(input logic [N_CHAN-1:0] stb);
        logic [N_CHAN-1:0][SAMPLE_W-1:0] data;
        @(posedge wclk);
        for (int c = 0; c < N_CHAN; c++) begin
            data[c] = SAMPLE_W'($urandom);
            if (stb[c]) begin
                hist[c][wr_idx[c]] = data[c];
                wr_idx[c]++;
            end
        end
        sample_stb_i <= stb;
        sample_i     <= data;
    endtask

    task automatic run_sparse(input int cycles);
        int                gap [N_CHAN];
        logic [N_CHAN-1:0] stb;
        for (int c = 0; c < N_CHAN; c++) begin
            gap[c] = 0;
        end
        for (int n = 0; n < cycles; n++) begin
            for (int c = 0; c < N_CHAN; c++) begin
                stb[c] = 1'b0;
                if (gap[c] > 0) begin
                    gap[c]--;
                end else if ($urandom_range(3) == 0) begin
                    stb[c] = 1'b1;
                    // 12 or more cycles to the next strobe
                    gap[c] = 11 + $urandom_range(7);
                end
            end
            drive_cycle(stb);
        end
    endtask

    task automatic run_pairs(input int cycles);
        int gap;
        gap = 0;
        for (int n = 0; n < cycles; n++) begin
            if (gap > 0) begin
                gap--;
                drive_cycle('0);
            end else begin
                drive_cycle('1);
                gap = 9 + $urandom_range(5);
            end
        end
    endtask

    task automatic run_backpressure(input int cycles);
        int                hold_start;
        int                hold_len;
        logic [N_CHAN-1:0] stb;
        hold_start = 20 + $urandom_range(20);
        hold_len   = 150 + $urandom_range(100);
        for (int n = 0; n < cycles; n++) begin
            if (n == hold_start) begin
                hold_req <= 1'b1;
            end
            if (n == hold_start + hold_len) begin
                hold_req <= 1'b0;
            end
            for (int c = 0; c < N_CHAN; c++) begin
                stb[c] = ($urandom_range(2) == 0);
            end
            drive_cycle(stb);
        end
        hold_req <= 1'b0;
    endtask

    task automatic wait_drained();
        bit busy;
        busy = 1'b1;
        while (busy) begin
            @(posedge wclk);
            busy = 1'b0;
            for (int c = 0; c < N_CHAN; c++) begin
                if (rd_idx[c] < wr_idx[c]) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    // no new output for a whole window
    task automatic wait_quiet();
        int last;
        last = -1;
        while (last != total_out) begin
            last = total_out;
            repeat (QUIET_CYC) @(posedge wclk);
        end
    endtask

    initial begin
        int seed_ret;
        rrst         = 1'b1;
        sample_stb_i = '0;
        sample_i     = '0;
        for (int c = 0; c < N_CHAN; c++) begin
            wr_idx[c]    = 0;
            rd_idx[c]    = 0;
            delivered[c] = 0;
        end
        seed_ret = $urandom(32'hac0e_3973);

        repeat (2) @(posedge wclk);
        rrst <= 1'b0;
        @(posedge wclk);
        compare_value(out_stb_o, 1'b0, "out_stb_o after reset");
        compare_value(overrun_o, '0, "overrun_o after reset");
        compare_value(seq_err_o, 1'b0, "seq_err_o after reset");

        run_sparse(SPARSE_CYC);
        drive_cycle('0);
        wait_drained();
        compare_value(overrun_o, '0, "overrun_o after sparse traffic");

        run_pairs(PAIR_CYC);
        drive_cycle('0);
        wait_drained();
        compare_value(overrun_o, '0, "overrun_o after paired strobes");

        allow_drop = 1'b1;
        run_backpressure(BP_CYC);
        drive_cycle('0);
        wait_quiet();
        // a last strobe per channel only gets through if nothing is left pending
        drive_cycle('1);
        drive_cycle('0);
        wait_drained();
        compare_value(overrun_o != '0, 1'b1, "back-pressure led to an overrun");
        for (int c = 0; c < N_CHAN; c++) begin
            compare_value(overrun_o[c], delivered[c] < wr_idx[c],
                          "overrun_o matches lost samples");
        end
        compare_value(seq_err_o, 1'b0, "seq_err_o at end of run");

        $display("All tests passed");
        $finish;
    end

endmodule
